// File: hdl/pulse_report_defs.svh
// pulse report sizes and rates
// widths of measured values, serial bit rate and report line layout

`ifndef PULSE_REPORT_DEFS_SVH
`define PULSE_REPORT_DEFS_SVH

// bits in a pulse count or a pulse duration
`define PR_VALUE_WIDTH 16

// decimal digits printed per value
`define PR_BCD_DIGITS 6

// clock cycles per serial bit, small so simulation stays short
`define PR_CLOCKS_PER_BIT 8

// clock cycles between reports, must be a power of two
`define PR_REPORT_PERIOD 2048

// six digits, space, six digits, CR, LF
`define PR_LINE_LENGTH 15

`endif

// File: hdl/meter_pkg.sv
// measurement types
// raw pulse values, their decimal form and the snapshot seen by the report

`include "pulse_report_defs.svh"

package meter_pkg;

	// one count or one duration in clock cycles
	typedef logic [`PR_VALUE_WIDTH-1:0] pulse_value_t;

	// packed BCD, most significant digit in the top nybble
	typedef logic [`PR_BCD_DIGITS*4-1:0] bcd_word_t;

	// values frozen for one report line
	typedef struct packed {
		pulse_value_t pulse_count;   // completed pulses since reset
		pulse_value_t last_duration; // high time of the latest completed pulse
	} meter_snapshot_t;

endpackage

// File: hdl/report_pkg.sv
// text report types
// characters, line position, sequencer states and the digit pair

`include "pulse_report_defs.svh"

package report_pkg;

	typedef logic [7:0] uart_byte_t;
	typedef logic [3:0] char_index_t; // position within one line

	typedef enum logic [2:0] {
		idle,
		convert,
		load,
		send,
		wait_done
	} report_state_t;

	typedef struct packed {
		meter_pkg::bcd_word_t count_digits;
		meter_pkg::bcd_word_t duration_digits;
	} bcd_pair_t;

	parameter uart_byte_t char_zero  = 8'h30; // ascii '0'
	parameter uart_byte_t char_space = 8'h20;
	parameter uart_byte_t char_cr    = 8'h0d;
	parameter uart_byte_t char_lf    = 8'h0a;

endpackage

// File: hdl/interval_timer.sv
// interval timer
// free-running counters giving the report tick and the serial bit tick

`include "pulse_report_defs.svh"

module interval_timer (
	input  logic clock,
	input  logic reset,
	output logic report_tick,
	output logic bit_tick
);

	localparam int report_bits = $clog2(`PR_REPORT_PERIOD);
	localparam int bit_bits    = $clog2(`PR_CLOCKS_PER_BIT);

	logic [report_bits-1:0] report_count;
	logic [bit_bits-1:0]    bit_count;

	// report period is a power of two, so this counter just rolls over
	always_ff @(posedge clock) begin
		if (reset) begin
			report_count <= '0;
		end else begin
			report_count <= report_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bit_count <= '0;
		end else if (bit_tick) begin
			bit_count <= '0; // wrap
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// ticks mark the last cycle of each period
	assign report_tick = (report_count == report_bits'(`PR_REPORT_PERIOD - 1));
	assign bit_tick    = (bit_count == bit_bits'(`PR_CLOCKS_PER_BIT - 1));

endmodule

// File: hdl/pulse_meter.sv
// pulse meter
// synchronizes the trigger, times each high pulse, counts completed pulses
// and freezes both values into a snapshot on request

`include "pulse_report_defs.svh"

module pulse_meter (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       trigger,
	input  logic                       capture,
	output meter_pkg::meter_snapshot_t snapshot
);

	logic trigger_meta;
	logic trigger_sync;
	logic trigger_prev; // history for edge detection
	logic falling_edge;

	meter_pkg::pulse_value_t    duration_count; // running length of current pulse
	meter_pkg::meter_snapshot_t live;

	always_ff @(posedge clock) begin
		if (reset) begin
			trigger_meta <= 1'b0;
			trigger_sync <= 1'b0;
			trigger_prev <= 1'b0;
		end else begin
			trigger_meta <= trigger;
			trigger_sync <= trigger_meta;
			trigger_prev <= trigger_sync;
		end
	end

	assign falling_edge = trigger_prev & ~trigger_sync;

	// a pulse is only counted once it has ended
	always_ff @(posedge clock) begin
		if (reset) begin
			duration_count     <= '0;
			live.pulse_count   <= '0;
			live.last_duration <= '0;
		end else if (falling_edge) begin
			live.last_duration <= duration_count;
			duration_count     <= '0;
			if (live.pulse_count != '1) begin
				live.pulse_count <= live.pulse_count + 1'b1;
			end
		end else if (trigger_sync && duration_count != '1) begin
			duration_count <= duration_count + 1'b1; // saturates
		end
	end

	// both values taken in the same cycle so the line is consistent
	always_ff @(posedge clock) begin
		if (capture) begin
			snapshot <= live;
		end
	end

endmodule

// File: hdl/hex_to_bcd.sv
// binary to bcd converter
// sequential double dabble, one shift-add-3 step per clock

`include "pulse_report_defs.svh"

module hex_to_bcd (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    start,
	input  meter_pkg::pulse_value_t value,
	output meter_pkg::bcd_word_t    digits,
	output logic                    done
);

	localparam int step_bits = $clog2(`PR_VALUE_WIDTH);

	logic                    running;
	logic [step_bits-1:0]    step;
	meter_pkg::pulse_value_t binary;   // bits still to be shifted in
	meter_pkg::bcd_word_t    bcd;
	meter_pkg::bcd_word_t    adjusted; // after add-3 on every digit
	meter_pkg::bcd_word_t    shifted;

	// add 3 to any digit of 5 or more before the shift
	always_comb begin
		for (int d = 0; d < `PR_BCD_DIGITS; d++) begin
			if (bcd[d*4 +: 4] >= 4'd5) begin
				adjusted[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
			end else begin
				adjusted[d*4 +: 4] = bcd[d*4 +: 4];
			end
		end
	end

	assign shifted = {adjusted[`PR_BCD_DIGITS*4-2:0], binary[`PR_VALUE_WIDTH-1]};

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
			step    <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				step    <= '0;
			end else if (running) begin
				if (step == step_bits'(`PR_VALUE_WIDTH - 1)) begin
					running <= 1'b0;
					done    <= 1'b1; // last step lands with done
				end else begin
					step <= step + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			binary <= value;
			bcd    <= '0;
		end else if (running) begin
			binary <= binary << 1;
			bcd    <= shifted;
		end
	end

	assign digits = bcd; // holds until the next start

endmodule

// File: hdl/report_sequencer.sv
// report sequencer
// on each report tick: snapshot, convert to decimal, then send one text line
// a character at a time through the serial transmitter

`include "pulse_report_defs.svh"

module report_sequencer (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   report_tick,
	input  logic                   convert_done,
	input  logic                   busy,
	input  report_pkg::bcd_pair_t  digits,
	output logic                   capture,
	output logic                   convert_start,
	output logic                   byte_start,
	output report_pkg::uart_byte_t byte_data
);

	localparam int space_pos = `PR_BCD_DIGITS;
	localparam int cr_pos    = `PR_LINE_LENGTH - 2;
	localparam int lf_pos    = `PR_LINE_LENGTH - 1;

	report_pkg::report_state_t state;
	report_pkg::char_index_t   char_index;

	// character at a given line position, digits most significant first
	function automatic report_pkg::uart_byte_t char_at(
		input report_pkg::char_index_t idx,
		input report_pkg::bcd_pair_t   pair
	);
		int         pos;
		logic [3:0] nybble;
		pos = int'(idx);
		if (pos < space_pos) begin
			nybble = pair.count_digits[(space_pos - 1 - pos)*4 +: 4];
		end else if (pos > space_pos && pos < cr_pos) begin
			nybble = pair.duration_digits[(cr_pos - 1 - pos)*4 +: 4];
		end else begin
			nybble = 4'h0;
		end
		if (pos == space_pos) begin
			return report_pkg::char_space;
		end else if (pos == cr_pos) begin
			return report_pkg::char_cr;
		end else if (pos == lf_pos) begin
			return report_pkg::char_lf;
		end
		return report_pkg::char_zero + {4'h0, nybble};
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= report_pkg::idle;
			char_index    <= '0;
			capture       <= 1'b0;
			convert_start <= 1'b0;
			byte_start    <= 1'b0;
		end else begin
			capture       <= 1'b0;
			convert_start <= 1'b0;
			byte_start    <= 1'b0;
			case (state)
				report_pkg::idle: begin
					if (report_tick) begin // ticks outside idle are dropped
						capture <= 1'b1;
						state   <= report_pkg::convert;
					end
				end
				report_pkg::convert: begin
					convert_start <= capture; // snapshot valid the cycle after capture
					if (convert_done) begin
						char_index <= '0;
						state      <= report_pkg::load;
					end
				end
				report_pkg::load: begin
					state <= report_pkg::send;
				end
				report_pkg::send: begin
					if (!busy) begin
						byte_start <= 1'b1;
						state      <= report_pkg::wait_done;
					end
				end
				report_pkg::wait_done: begin
					// busy only rises the cycle after byte_start
					if (!byte_start && !busy) begin
						if (char_index == report_pkg::char_index_t'(lf_pos)) begin
							state <= report_pkg::idle;
						end else begin
							char_index <= char_index + 1'b1;
							state      <= report_pkg::load;
						end
					end
				end
				default: state <= report_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == report_pkg::load) begin
			byte_data <= char_at(char_index, digits);
		end
	end

endmodule

// File: hdl/uart_tx.sv
// 8N1 serial transmitter
// start bit, eight data bits lsb first, stop bit, one bit per bit tick

`include "pulse_report_defs.svh"

module uart_tx (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   bit_tick,
	input  logic                   byte_start,
	input  report_pkg::uart_byte_t byte_data,
	output logic                   busy,
	output logic                   tx
);

	localparam int frame_bits = 10;

	logic [frame_bits-1:0] frame;     // bits still to go out, lsb next
	logic [3:0]            bits_left;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy      <= 1'b0;
			tx        <= 1'b1; // line idles high
			bits_left <= '0;
		end else if (!busy) begin
			if (byte_start) begin
				busy      <= 1'b1;
				bits_left <= 4'(frame_bits);
			end
		end else if (bit_tick) begin
			if (bits_left == '0) begin
				busy <= 1'b0; // stop bit has had its full period
			end else begin
				tx        <= frame[0];
				bits_left <= bits_left - 1'b1;
			end
		end
	end

	// start bit, data and stop bit loaded together
	always_ff @(posedge clock) begin
		if (!busy && byte_start) begin
			frame <= {1'b1, byte_data, 1'b0};
		end else if (busy && bit_tick) begin
			frame <= {1'b1, frame[frame_bits-1:1]}; // shift in idle level
		end
	end

endmodule

// File: hdl/pulse_report_top.sv
// pulse report top level
// measures trigger pulses and prints count and last duration as serial text

`include "pulse_report_defs.svh"

module pulse_report_top (
	input  logic clock,
	input  logic reset,
	input  logic trigger,
	output logic tx
);

	logic report_tick;
	logic bit_tick;
	logic capture;
	logic convert_start;
	logic convert_done;
	logic byte_start;
	logic busy;

	meter_pkg::meter_snapshot_t snapshot;
	meter_pkg::bcd_word_t       count_digits;
	meter_pkg::bcd_word_t       duration_digits;
	report_pkg::bcd_pair_t      digit_pair;
	report_pkg::uart_byte_t     byte_data;

	interval_timer timer (
		.clock      (clock),
		.reset      (reset),
		.report_tick(report_tick),
		.bit_tick   (bit_tick)
	);

	pulse_meter meter (
		.clock   (clock),
		.reset   (reset),
		.trigger (trigger),
		.capture (capture),
		.snapshot(snapshot)
	);

	// both converters run in lockstep, the count one paces the sequencer
	hex_to_bcd count_bcd (
		.clock (clock),
		.reset (reset),
		.start (convert_start),
		.value (snapshot.pulse_count),
		.digits(count_digits),
		.done  (convert_done)
	);

	hex_to_bcd duration_bcd (
		.clock (clock),
		.reset (reset),
		.start (convert_start),
		.value (snapshot.last_duration),
		.digits(duration_digits),
		.done  ()
	);

	assign digit_pair = '{count_digits: count_digits, duration_digits: duration_digits};

	report_sequencer sequencer (
		.clock        (clock),
		.reset        (reset),
		.report_tick  (report_tick),
		.convert_done (convert_done),
		.busy         (busy),
		.digits       (digit_pair),
		.capture      (capture),
		.convert_start(convert_start),
		.byte_start   (byte_start),
		.byte_data    (byte_data)
	);

	uart_tx transmitter (
		.clock     (clock),
		.reset     (reset),
		.bit_tick  (bit_tick),
		.byte_start(byte_start),
		.byte_data (byte_data),
		.busy      (busy),
		.tx        (tx)
	);

endmodule

// File: test/tb_clock_gen.sv
// testbench clock and reset
// 40 ns clock, reset held high for the first four rising edges

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int half_period  = 20; // ns
	localparam int reset_cycles = 4;

	initial begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0; // released on a rising edge
	end

endmodule

// File: test/pulse_report_tb.sv
// pulse report testbench
// drives trigger pulses, decodes the serial report lines and checks them
// against a model of the completed pulses

`include "pulse_report_defs.svh"

module pulse_report_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int period        = `PR_REPORT_PERIOD;
	localparam int bit_cycles    = `PR_CLOCKS_PER_BIT;
	localparam int line_len      = `PR_LINE_LENGTH;
	localparam int space_pos     = `PR_BCD_DIGITS;
	localparam int cr_pos        = `PR_LINE_LENGTH - 2;
	localparam int lf_pos        = `PR_LINE_LENGTH - 1;
	localparam int value_max     = (1 << `PR_VALUE_WIDTH) - 1;
	localparam int report_total  = 48; // ticks over all phases below
	localparam int timeout_limit = report_total * period + 4096;

	typedef logic [line_len*8-1:0] line_t; // first character in the top byte

	logic clock;
	logic reset;
	logic trigger;
	logic tx;

	int    cycle = 0; // rising edges since reset release
	int    ticks_seen = 0;
	int    lines_done = 0;
	int    timeout_count = 0;
	string test_name;

	meter_pkg::pulse_value_t model_count; // completed pulses, saturating
	meter_pkg::pulse_value_t model_dur;   // length of the latest one

	meter_pkg::pulse_value_t exp_count_q[$];
	meter_pkg::pulse_value_t exp_dur_q[$];
	string                   exp_name_q[$];

	tb_clock_gen clock_gen (
		.clock(clock),
		.reset(reset)
	);

	pulse_report_top DUT (
		.clock  (clock),
		.reset  (reset),
		.trigger(trigger),
		.tx     (tx)
	);

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_byte(input string name, input report_pkg::uart_byte_t expected,
			input report_pkg::uart_byte_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch %s expected 0x%02h actual 0x%02h",
				name, expected, actual));
		end
	endtask

	task automatic check_value(input string name, input meter_pkg::pulse_value_t expected,
			input meter_pkg::pulse_value_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	function automatic report_pkg::uart_byte_t char_of(input line_t text, input int pos);
		return text[(line_len - 1 - pos)*8 +: 8];
	endfunction

	// expected text of six decimal digits, space, six digits, CR and LF
	function automatic line_t format_line(input meter_pkg::pulse_value_t count,
			input meter_pkg::pulse_value_t dur);
		line_t text;
		int    c;
		int    d;
		c = int'(count);
		d = int'(dur);
		text = '0;
		for (int i = space_pos - 1; i >= 0; i--) begin
			text[(line_len - 1 - i)*8 +: 8] = 8'h30 + 8'(c % 10);
			c = c / 10;
		end
		for (int i = cr_pos - 1; i > space_pos; i--) begin
			text[(line_len - 1 - i)*8 +: 8] = 8'h30 + 8'(d % 10);
			d = d / 10;
		end
		text[(line_len - 1 - space_pos)*8 +: 8] = 8'h20;
		text[(line_len - 1 - cr_pos)*8 +: 8]    = 8'h0d;
		text[(line_len - 1 - lf_pos)*8 +: 8]    = 8'h0a;
		return text;
	endfunction

	// one clock, and the model is frozen on every tick cycle
	task automatic step();
		@(posedge clock);
		cycle++;
		if (cycle % period == period - 1) begin
			exp_count_q.push_back(model_count);
			exp_dur_q.push_back(model_dur);
			exp_name_q.push_back(test_name);
			ticks_seen++;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) step();
	endtask

	task automatic run_to_next_period();
		do begin
			step();
		end while (cycle % period != 0);
	endtask

	// keeps falling edges 4 cycles away from any tick
	function automatic bit near_tick(input int fall_cycle);
		int ph;
		ph = fall_cycle % period;
		return (ph >= period - 5) || (ph <= 3);
	endfunction

	task automatic drive_pulse(input int len);
		while (near_tick(cycle + 1 + len)) begin
			step();
		end
		step();
		trigger <= 1'b1;
		repeat (len) step();
		trigger <= 1'b0;
		if (model_count != '1) begin
			model_count = model_count + 1'b1;
		end
		model_dur = (len > value_max) ? '1 : meter_pkg::pulse_value_t'(len);
	endtask

	task automatic check_line(input line_t got);
		line_t                   expected;
		meter_pkg::pulse_value_t exp_count;
		meter_pkg::pulse_value_t exp_dur;
		report_pkg::uart_byte_t  ch;
		string                   name;
		int                      count_val;
		int                      dur_val;
		if (exp_count_q.size() == 0) begin
			fail_run("a report line arrived with no report tick before it");
		end
		exp_count = exp_count_q.pop_front();
		exp_dur   = exp_dur_q.pop_front();
		name      = exp_name_q.pop_front();
		expected  = format_line(exp_count, exp_dur);
		check_byte({name, " space"}, char_of(expected, space_pos), char_of(got, space_pos));
		check_byte({name, " cr"}, char_of(expected, cr_pos), char_of(got, cr_pos));
		check_byte({name, " lf"}, char_of(expected, lf_pos), char_of(got, lf_pos));
		count_val = 0;
		dur_val   = 0;
		for (int i = 0; i < cr_pos; i++) begin
			ch = char_of(got, i);
			if (i != space_pos) begin
				if (ch < 8'h30 || ch > 8'h39) begin
					fail_run($sformatf("%s: character %0d of the line is not a decimal digit",
						name, i));
				end
				if (i < space_pos) begin
					count_val = count_val * 10 + int'(ch - 8'h30);
				end else begin
					dur_val = dur_val * 10 + int'(ch - 8'h30);
				end
			end
		end
		check_value({name, " count"}, exp_count, meter_pkg::pulse_value_t'(count_val));
		check_value({name, " duration"}, exp_dur, meter_pkg::pulse_value_t'(dur_val));
		for (int i = 0; i < line_len; i++) begin
			check_byte($sformatf("%s char %0d", name, i), char_of(expected, i), char_of(got, i));
		end
		lines_done++;
	endtask

	// serial decoder sampling on falling clock edges near mid-bit
	initial begin : decoder
		report_pkg::uart_byte_t rx_byte;
		line_t                  line_bits;
		int                     pos;
		pos = 0;
		line_bits = '0;
		wait (!reset);
		forever begin
			@(negedge clock);
			if (tx === 1'b0) begin
				repeat (bit_cycles/2 - 1) @(negedge clock);
				if (tx !== 1'b0) begin
					fail_run("start bit on the serial line was shorter than half a bit");
				end
				for (int b = 0; b < 8; b++) begin
					repeat (bit_cycles) @(negedge clock);
					rx_byte[b] = tx; // lsb first
				end
				repeat (bit_cycles) @(negedge clock);
				if (tx !== 1'b1) begin
					fail_run("stop bit on the serial line was not high");
				end
				line_bits = {line_bits[line_len*8-9:0], rx_byte};
				pos++;
				if (pos == line_len) begin
					check_line(line_bits);
					pos = 0;
				end
			end
		end
	end

	// no frame may start before the first report
	always @(negedge clock) begin
		if (!reset && cycle < period && tx !== 1'b1) begin
			fail_run("tx left the idle level before the first report");
		end
	end

	always @(posedge clock) begin
		timeout_count++;
		if (timeout_count > timeout_limit) begin
			fail_run("timeout, the report lines did not all arrive in time");
		end
	end

	initial begin : stimulus
		int n_pulses;
		trigger     = 1'b0;
		model_count = '0;
		model_dur   = '0;
		void'($urandom(32));
		wait (!reset);

		test_name = "reset_idle";
		run_to_next_period();

		test_name = "single_pulse";
		repeat (6) begin
			idle($urandom_range(1000, 10));
			drive_pulse($urandom_range(300, 1));
			run_to_next_period();
		end

		test_name = "multi_pulse";
		repeat (4) begin
			idle($urandom_range(200, 10));
			n_pulses = $urandom_range(6, 2);
			repeat (n_pulses) begin
				drive_pulse($urandom_range(150, 1));
				idle($urandom_range(60, 3));
			end
			run_to_next_period();
		end

		// a pulse still high at the tick shows up one line later
		test_name = "pulse_across_tick";
		while (cycle % period != period - 100) begin
			step();
		end
		drive_pulse(300);
		run_to_next_period();

		test_name = "duration_saturation";
		drive_pulse(70000);
		run_to_next_period();

		while (lines_done < ticks_seen) begin
			step();
		end
		$display("Verification passed");
		$finish;
	end

endmodule

// File: pulse_report_top.f
+incdir+hdl
hdl/meter_pkg.sv
hdl/report_pkg.sv
hdl/interval_timer.sv
hdl/pulse_meter.sv
hdl/hex_to_bcd.sv
hdl/report_sequencer.sv
hdl/uart_tx.sv
hdl/pulse_report_top.sv
test/tb_clock_gen.sv
test/pulse_report_tb.sv

// File: Bender.yml
package:
  name: pulse_report

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/meter_pkg.sv
      - hdl/report_pkg.sv
      - hdl/interval_timer.sv
      - hdl/pulse_meter.sv
      - hdl/hex_to_bcd.sv
      - hdl/report_sequencer.sv
      - hdl/uart_tx.sv
      - hdl/pulse_report_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_clock_gen.sv
      - test/pulse_report_tb.sv
